// File: rtl/ilk_defs.svh
`ifndef ILK_DEFS_SVH
`define ILK_DEFS_SVH

// shared sizing for the interlaken transmit front end

// 64-bit words per beat
// the avalon side and the interlaken side carry the same beat width
`define ILK_WORDS 4

// beats held in the decoupling FIFO
// must be a power of two because the pointers wrap naturally
`define ILK_FIFO_DEPTH 8

// longest burst in beats
// a burst may also close earlier on end of packet
`define ILK_BURST_MAX 4

`endif

// File: rtl/ilk_pkg.sv
`default_nettype none

`include "ilk_defs.svh"

package ilk_pkg;

   // one beat of payload, ILK_WORDS words of 64 bits
   typedef logic [`ILK_WORDS*64-1:0] ilk_data_t;

   // avalon empty byte count, 0 to 31 in a 32-byte beat
   typedef logic [4:0] avl_empty_t;

   // number of valid 64-bit words, 0 to 4
   typedef logic [2:0] ilk_nvalid_t;

   // end of packet code
   // 0000 no eop, 0001 eop with error
   // 1xxx eop with xxx valid bytes in the last word, 000 meaning 8
   typedef logic [3:0] ilk_eop_t;

   // FIFO pointer, address bits plus one wrap bit on top
   typedef logic [$clog2(`ILK_FIFO_DEPTH):0] ilk_fifo_ptr_t;

endpackage

`default_nettype wire

// File: rtl/avalon_to_ilk_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module avalon_to_ilk_adapter
   import ilk_pkg::*;
(
   // avalon streaming side
   input  ilk_data_t   avl_data,
   input  logic        avl_sop,
   input  logic        avl_eop,
   input  logic        avl_valid,
   input  avl_empty_t  avl_empty,
   input  logic        avl_error,
   output logic        avl_ready,

   // interlaken word side
   output ilk_data_t   ilk_data,
   output ilk_nvalid_t ilk_num_valid,
   output logic        ilk_sop,
   output ilk_eop_t    ilk_eopbits,
   output logic        ilk_valid,
   input  logic        ilk_ready
);

   // qualified eop and eop with error
   logic valid_eop;
   logic valid_eop_error;

   assign valid_eop       = avl_valid & avl_eop;
   assign valid_eop_error = valid_eop & avl_error;

   // payload and handshake pass straight across, no storage here
   assign ilk_data  = avl_data;
   assign ilk_sop   = avl_sop;
   assign ilk_valid = avl_valid;

   // back-pressure from the FIFO goes straight to the source
   assign avl_ready = ilk_ready;

   always_comb begin
      // idle beat carries nothing
      ilk_num_valid = '0;
      ilk_eopbits   = 4'b0000;

      if (avl_valid && !avl_eop) begin
         // mid-packet beat, empty should be a whole number of words
         case (avl_empty)
            5'd0:    ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS);
            5'd8:    ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 1);
            5'd16:   ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 2);
            5'd24:   ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 3);
            // partial word before eop is not legal, flag as empty beat
            default: ilk_num_valid = '0;
         endcase
      end else if (valid_eop) begin
         // last beat, count any word that holds at least one byte
         if (avl_empty < 5'd8) begin
            ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS);
         end else if (avl_empty < 5'd16) begin
            ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 1);
         end else if (avl_empty < 5'd24) begin
            ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 2);
         end else begin
            ilk_num_valid = ilk_nvalid_t'(`ILK_WORDS - 3);
         end

         if (valid_eop_error) begin
            // error marker replaces the byte count
            ilk_eopbits = 4'b0001;
         end else begin
            // empty[2:0] = k unused bytes in the last word, so 8-k valid
            // a full last word wraps to 000
            case (avl_empty[2:0])
               3'd0: ilk_eopbits = 4'b1000;
               3'd1: ilk_eopbits = 4'b1111;
               3'd2: ilk_eopbits = 4'b1110;
               3'd3: ilk_eopbits = 4'b1101;
               3'd4: ilk_eopbits = 4'b1100;
               3'd5: ilk_eopbits = 4'b1011;
               3'd6: ilk_eopbits = 4'b1010;
               3'd7: ilk_eopbits = 4'b1001;
               default: ilk_eopbits = 4'b1000;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/ilk_word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_word_fifo
   import ilk_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,

   // write side, from the adapter
   input  ilk_data_t   wr_data,
   input  ilk_nvalid_t wr_num_valid,
   input  logic        wr_sop,
   input  ilk_eop_t    wr_eopbits,
   input  logic        wr_valid,
   output logic        wr_ready,

   // read side, to the burst framer
   output ilk_data_t   rd_data,
   output ilk_nvalid_t rd_num_valid,
   output logic        rd_sop,
   output ilk_eop_t    rd_eopbits,
   output logic        rd_valid,
   input  logic        rd_ready
);

   localparam int unsigned ADDR_W = $clog2(`ILK_FIFO_DEPTH);

   // entry storage, one array per field
   ilk_data_t     data_mem   [`ILK_FIFO_DEPTH];
   ilk_nvalid_t   nvalid_mem [`ILK_FIFO_DEPTH];
   logic          sop_mem    [`ILK_FIFO_DEPTH];
   ilk_eop_t      eop_mem    [`ILK_FIFO_DEPTH];

   ilk_fifo_ptr_t wr_ptr;
   ilk_fifo_ptr_t rd_ptr;
   logic          accept_en;
   logic          full;
   logic          empty;
   logic          do_write;
   logic          do_read;

   // same address, wrap bits equal means empty, wrap bits differ means full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // accept_en holds the write side closed until the first edge after reset
   assign wr_ready = accept_en & ~full;
   assign rd_valid = ~empty;

   assign do_write = wr_valid & wr_ready;
   assign do_read  = rd_valid & rd_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         accept_en <= 1'b0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
      end else begin
         accept_en <= 1'b1;
         // read and write may both move in one cycle
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         data_mem[wr_ptr[ADDR_W-1:0]]   <= wr_data;
         nvalid_mem[wr_ptr[ADDR_W-1:0]] <= wr_num_valid;
         sop_mem[wr_ptr[ADDR_W-1:0]]    <= wr_sop;
         eop_mem[wr_ptr[ADDR_W-1:0]]    <= wr_eopbits;
      end
   end

   // head entry is read combinationally, visible right after the write edge
   assign rd_data      = data_mem[rd_ptr[ADDR_W-1:0]];
   assign rd_num_valid = nvalid_mem[rd_ptr[ADDR_W-1:0]];
   assign rd_sop       = sop_mem[rd_ptr[ADDR_W-1:0]];
   assign rd_eopbits   = eop_mem[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// File: rtl/ilk_burst_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_burst_framer
   import ilk_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,

   // beats from the FIFO
   input  ilk_data_t   in_data,
   input  ilk_nvalid_t in_num_valid,
   input  logic        in_sop,
   input  ilk_eop_t    in_eopbits,
   input  logic        in_valid,
   output logic        in_ready,

   // beats towards the lanes, with burst boundary
   output ilk_data_t   out_data,
   output ilk_nvalid_t out_num_valid,
   output logic        out_sop,
   output ilk_eop_t    out_eopbits,
   output logic        out_burst_end,
   output logic        out_valid,
   input  logic        out_ready
);

   // wide enough to count up to ILK_BURST_MAX-1
   localparam int unsigned CNT_W = (`ILK_BURST_MAX > 1) ? $clog2(`ILK_BURST_MAX) : 1;

   // beats already sent in the current burst
   logic [CNT_W-1:0] beat_cnt;
   logic             last_slot;
   logic             out_fire;

   // data path is combinational, framing only adds the burst_end flag
   assign out_data      = in_data;
   assign out_num_valid = in_num_valid;
   assign out_sop       = in_sop;
   assign out_eopbits   = in_eopbits;
   assign out_valid     = in_valid;
   assign in_ready      = out_ready;

   // this beat fills the burst to its maximum length
   assign last_slot = (beat_cnt == CNT_W'(`ILK_BURST_MAX - 1));

   // any non-zero eop code, error included, closes the burst
   assign out_burst_end = (in_eopbits != 4'b0000) || last_slot;

   assign out_fire = out_valid & out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         beat_cnt <= '0;
      end else if (out_fire) begin
         if (out_burst_end) begin
            // next beat opens a new burst
            beat_cnt <= '0;
         end else begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/ilk_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module ilk_tx_top
   import ilk_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,

   // avalon streaming input
   input  ilk_data_t   avl_data,
   input  logic        avl_sop,
   input  logic        avl_eop,
   input  logic        avl_valid,
   input  avl_empty_t  avl_empty,
   input  logic        avl_error,
   output logic        avl_ready,

   // interlaken beat output
   output ilk_data_t   ilk_data,
   output ilk_nvalid_t ilk_num_valid,
   output logic        ilk_sop,
   output ilk_eop_t    ilk_eopbits,
   output logic        ilk_burst_end,
   output logic        ilk_valid,
   input  logic        ilk_ready
);

   // adapter to FIFO
   ilk_data_t   a2f_data;
   ilk_nvalid_t a2f_num_valid;
   logic        a2f_sop;
   ilk_eop_t    a2f_eopbits;
   logic        a2f_valid;
   logic        a2f_ready;

   // FIFO to framer
   ilk_data_t   f2b_data;
   ilk_nvalid_t f2b_num_valid;
   logic        f2b_sop;
   ilk_eop_t    f2b_eopbits;
   logic        f2b_valid;
   logic        f2b_ready;

   // avalon beat to word count and eop code, zero latency
   avalon_to_ilk_adapter adapter_inst (
      .avl_data      (avl_data),
      .avl_sop       (avl_sop),
      .avl_eop       (avl_eop),
      .avl_valid     (avl_valid),
      .avl_empty     (avl_empty),
      .avl_error     (avl_error),
      .avl_ready     (avl_ready),
      .ilk_data      (a2f_data),
      .ilk_num_valid (a2f_num_valid),
      .ilk_sop       (a2f_sop),
      .ilk_eopbits   (a2f_eopbits),
      .ilk_valid     (a2f_valid),
      .ilk_ready     (a2f_ready)
   );

   // decoupling buffer, one cycle from write to output
   ilk_word_fifo fifo_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .wr_data      (a2f_data),
      .wr_num_valid (a2f_num_valid),
      .wr_sop       (a2f_sop),
      .wr_eopbits   (a2f_eopbits),
      .wr_valid     (a2f_valid),
      .wr_ready     (a2f_ready),
      .rd_data      (f2b_data),
      .rd_num_valid (f2b_num_valid),
      .rd_sop       (f2b_sop),
      .rd_eopbits   (f2b_eopbits),
      .rd_valid     (f2b_valid),
      .rd_ready     (f2b_ready)
   );

   // burst boundary marking on the way out
   ilk_burst_framer framer_inst (
      .clk           (clk),
      .arst_n        (arst_n),
      .in_data       (f2b_data),
      .in_num_valid  (f2b_num_valid),
      .in_sop        (f2b_sop),
      .in_eopbits    (f2b_eopbits),
      .in_valid      (f2b_valid),
      .in_ready      (f2b_ready),
      .out_data      (ilk_data),
      .out_num_valid (ilk_num_valid),
      .out_sop       (ilk_sop),
      .out_eopbits   (ilk_eopbits),
      .out_burst_end (ilk_burst_end),
      .out_valid     (ilk_valid),
      .out_ready     (ilk_ready)
   );

endmodule

`default_nettype wire

// File: verification/ilk_tx_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_tx_checker
   import ilk_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,

   // avalon side of the DUT
   input  ilk_data_t   avl_data,
   input  logic        avl_sop,
   input  logic        avl_eop,
   input  logic        avl_valid,
   input  avl_empty_t  avl_empty,
   input  logic        avl_error,
   input  logic        avl_ready,

   // interlaken side of the DUT
   input  ilk_data_t   ilk_data,
   input  ilk_nvalid_t ilk_num_valid,
   input  logic        ilk_sop,
   input  ilk_eop_t    ilk_eopbits,
   input  logic        ilk_burst_end,
   input  logic        ilk_valid,
   input  logic        ilk_ready,

   output int          error_count,
   output int          checked_count,
   output int          pending_count
);

   // expected beats in input order
   ilk_data_t   exp_data [$];
   logic        exp_sop  [$];
   ilk_nvalid_t exp_nv   [$];
   ilk_eop_t    exp_eop  [$];

   ilk_data_t   head_data;
   logic        head_sop;
   ilk_nvalid_t head_nv;
   ilk_eop_t    head_eop;
   logic        exp_burst_end;

   // beats sent since the last burst end
   int burst_cnt = 0;
   int errors    = 0;
   int checked   = 0;
   int pending   = 0;

   assign error_count   = errors;
   assign checked_count = checked;
   assign pending_count = pending;

   // each full 8 empty bytes removes one word
   // mid-packet beats must drop whole words or carry nothing
   function automatic ilk_nvalid_t expected_num_valid(input logic eop, input avl_empty_t empty);
      if (!eop && (int'(empty) % 8 != 0)) begin
         return '0;
      end
      return ilk_nvalid_t'(`ILK_WORDS - int'(empty) / 8);
   endfunction

   // last word holds 8 minus (empty mod 8) bytes, 8 wraps to 000
   function automatic ilk_eop_t expected_eopbits(input logic eop, input logic error,
                                                 input avl_empty_t empty);
      int bytes;
      if (!eop) begin
         return 4'b0000;
      end
      if (error) begin
         return 4'b0001;
      end
      bytes = 8 - (int'(empty) % 8);
      return {1'b1, bytes[2:0]};
   endfunction

   task automatic compare_field(input string name, input logic [255:0] expected,
                                input logic [255:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("Fail t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   always @(posedge clk) begin
      if (!arst_n) begin
         // nothing may enter or leave while reset is held
         compare_field("ilk_valid", 1'b0, ilk_valid);
         compare_field("avl_ready", 1'b0, avl_ready);
         burst_cnt = 0;
      end else begin
         // output side first, an input beat never leaves on its own edge
         if (ilk_valid && ilk_ready) begin
            if (exp_data.size() == 0) begin
               errors++;
               $display("output beat at t=%0t arrived with no input beat pending", $time);
            end else begin
               head_data = exp_data.pop_front();
               head_sop  = exp_sop.pop_front();
               head_nv   = exp_nv.pop_front();
               head_eop  = exp_eop.pop_front();
               // burst closes on eop or when it reaches its maximum length
               exp_burst_end = (head_eop != 4'b0000) || (burst_cnt == `ILK_BURST_MAX - 1);
               compare_field("ilk_data", head_data, ilk_data);
               compare_field("ilk_sop", head_sop, ilk_sop);
               compare_field("ilk_num_valid", head_nv, ilk_num_valid);
               compare_field("ilk_eopbits", head_eop, ilk_eopbits);
               compare_field("ilk_burst_end", exp_burst_end, ilk_burst_end);
               burst_cnt = exp_burst_end ? 0 : burst_cnt + 1;
               checked++;
            end
         end
         // transferred input beat becomes an expected output beat
         if (avl_valid && avl_ready) begin
            exp_data.push_back(avl_data);
            exp_sop.push_back(avl_sop);
            exp_nv.push_back(expected_num_valid(avl_eop, avl_empty));
            exp_eop.push_back(expected_eopbits(avl_eop, avl_error, avl_empty));
         end
      end
      pending = exp_data.size();
   end

endmodule

`default_nettype wire

// File: verification/ilk_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_tx_tb
   import ilk_pkg::*;
();

   localparam int WAIT_LIMIT = 100;
   localparam int SIM_LIMIT  = 100000;

   logic        clk;
   logic        arst_n;
   ilk_data_t   avl_data;
   logic        avl_sop;
   logic        avl_eop;
   logic        avl_valid;
   avl_empty_t  avl_empty;
   logic        avl_error;
   logic        avl_ready;
   ilk_data_t   ilk_data;
   ilk_nvalid_t ilk_num_valid;
   logic        ilk_sop;
   ilk_eop_t    ilk_eopbits;
   logic        ilk_burst_end;
   logic        ilk_valid;
   logic        ilk_ready;

   int     chk_errors;
   int     chk_checked;
   int     pending;
   int     tb_errors;
   integer seed;
   // 0 means output always ready, 1 output held off and 2 random ready
   int     ready_mode;
   logic   watch_stall;
   logic   saw_stall;
   logic   next_ready;

   ilk_tx_top ilk_tx_top_inst (.*);

   ilk_tx_checker checker_inst (.*, .error_count(chk_errors),
                                .checked_count(chk_checked), .pending_count(pending));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // output back-pressure chosen at the edge and driven 1 ns later
   always @(posedge clk) begin
      if (ready_mode == 2) next_ready = ($random(seed) & 3) != 0;
      else next_ready = (ready_mode == 0);
      #1 ilk_ready = next_ready;
   end

   // source waiting on a full FIFO
   always @(posedge clk) begin
      if (watch_stall && avl_valid && !avl_ready) saw_stall = 1'b1;
   end

   function automatic ilk_data_t random_data();
      ilk_data_t d;
      for (int i = 0; i < `ILK_WORDS * 2; i++) d[i*32 +: 32] = $random(seed);
      return d;
   endfunction

   // called 1 ns after an edge and returns 1 ns after the transfer edge
   task automatic send_beat(input ilk_data_t data, input logic sop, input logic eop,
                            input avl_empty_t empty, input logic error);
      int cycles;
      logic done;
      avl_data  = data;
      avl_sop   = sop;
      avl_eop   = eop;
      avl_empty = empty;
      avl_error = error;
      avl_valid = 1'b1;
      cycles = 0;
      done = 1'b0;
      while (!done && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         done = avl_ready;
         cycles++;
      end
      if (!done) begin
         tb_errors++;
         $display("timeout at t=%0t, avl_ready stayed low for a whole beat", $time);
      end
      #1 avl_valid = 1'b0;
   endtask

   task automatic send_packet(input int beats, input avl_empty_t last_empty, input logic error);
      for (int i = 0; i < beats; i++) begin
         if (i == beats - 1) send_beat(random_data(), i == 0, 1'b1, last_empty, error);
         else send_beat(random_data(), i == 0, 1'b0, 5'd0, 1'b0);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (pending != 0 && cycles < WAIT_LIMIT) begin
         idle_cycles(1);
         cycles++;
      end
      if (pending != 0) begin
         tb_errors++;
         $display("timeout at t=%0t, %0d beats never left the DUT", $time, pending);
      end
   endtask

   task automatic wait_ready_after_reset();
      int cycles;
      cycles = 0;
      while (!avl_ready && cycles < WAIT_LIMIT) begin
         idle_cycles(1);
         cycles++;
      end
      if (!avl_ready) begin
         tb_errors++;
         $display("avl_ready did not rise after reset was released");
      end
   endtask

   initial begin
      int n;
      int gap;
      seed = 3;
      tb_errors = 0;
      ready_mode = 0;
      watch_stall = 1'b0;
      saw_stall = 1'b0;
      arst_n = 1'b1;
      ilk_ready = 1'b0;
      avl_data = '0;
      avl_sop = 1'b0;
      avl_eop = 1'b0;
      avl_valid = 1'b0;
      avl_empty = '0;
      avl_error = 1'b0;
      // falling edge gives the async reset a real event
      #2 arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;
      wait_ready_after_reset();
      // one beat through an idle DUT
      send_beat(random_data(), 1'b1, 1'b1, 5'd0, 1'b0);
      wait_drain();
      // every empty value on eop both clean and with error
      for (int err = 0; err < 2; err++) begin
         for (int e = 0; e < 32; e++) begin
            send_beat(random_data(), 1'b1, 1'b1, avl_empty_t'(e), err != 0);
         end
      end
      wait_drain();
      // mid-packet beats that drop whole words
      for (int e = 0; e < 4; e++) begin
         send_beat(random_data(), e == 0, 1'b0, avl_empty_t'(e * 8), 1'b0);
      end
      send_beat(random_data(), 1'b0, 1'b1, 5'd3, 1'b0);
      wait_drain();
      // hold the output off long enough to fill the FIFO
      ready_mode = 1;
      watch_stall = 1'b1;
      fork
         begin
            repeat (30) @(posedge clk);
            #1 ready_mode = 0;
         end
      join_none
      send_packet(6, 5'd9, 1'b0);
      send_packet(6, 5'd0, 1'b0);
      wait_drain();
      watch_stall = 1'b0;
      if (!saw_stall) begin
         tb_errors++;
         $display("avl_ready never went low while the output was held off");
      end
      // random packets against random back-pressure
      ready_mode = 2;
      repeat (60) begin
         n = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
         gap = $random(seed) & 3;
         send_packet(n, avl_empty_t'($random(seed)), ($random(seed) & 7) == 0);
         idle_cycles(gap);
      end
      ready_mode = 0;
      wait_drain();
      $display("checked %0d beats, %0d errors (%0d checker, %0d testbench)",
               chk_checked, chk_errors + tb_errors, chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      #(SIM_LIMIT);
      $display("simulation time limit reached before the test sequence ended");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/ilk_pkg.sv
rtl/avalon_to_ilk_adapter.sv
rtl/ilk_word_fifo.sv
rtl/ilk_burst_framer.sv
rtl/ilk_tx_top.sv
verification/ilk_tx_checker.sv
verification/ilk_tx_tb.sv

// File: Bender.yml
package:
  name: ilk_tx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ilk_pkg.sv
      - rtl/avalon_to_ilk_adapter.sv
      - rtl/ilk_word_fifo.sv
      - rtl/ilk_burst_framer.sv
      - rtl/ilk_tx_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/ilk_tx_checker.sv
      - verification/ilk_tx_tb.sv
